/* verilog.f */
wb_pkg.sv
gpr_file.sv
wb_stage.sv
retire_decode.sv
retire_stats.sv
wb_top.sv
tb_wb_top.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_wb_top
FILELIST := verilog.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass or fail comes from the pass line in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJDIR)

/* tb_wb_top.sv */
module tb_wb_top import wb_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_writes = 40;
	localparam int n_random = 300;
	// register writes, the x0 write, 16 memory ops, 9 jumps, random mix
	localparam int n_instr = n_writes + 1 + 16 + 9 + n_random;
	localparam int watchdog_cycles = n_instr * 40 + 500;

	logic            clk;
	logic            rst;
	logic            mem_in_valid;
	mem_in_t         mem_in;
	logic            stall;
	reg_addr_t       dbg_addr;
	logic            mem_in_ready;
	logic            retire_valid;
	retire_rec_t     retire_rec;
	retire_stats_t   stats;
	logic [xlen-1:0] dbg_data;

	// reference model state
	logic [xlen-1:0] model_regs [gpr_count];
	retire_rec_t     exp_q [$];
	retire_rec_t     exp_head;
	retire_stats_t   exp_stats;
	logic [xlen-1:0] pc;
	int              stall_rate;
	int              offered;
	int              seen;
	int              mismatches;
	int              failures;

	wb_top dut (
		.clk          (clk),
		.rst          (rst),
		.mem_in_valid (mem_in_valid),
		.mem_in       (mem_in),
		.stall        (stall),
		.dbg_addr     (dbg_addr),
		.mem_in_ready (mem_in_ready),
		.retire_valid (retire_valid),
		.retire_rec   (retire_rec),
		.stats        (stats),
		.dbg_data     (dbg_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input reg_addr_t rd,
			input logic [2:0] f3, input reg_addr_t rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [2:0] f3, input reg_addr_t rs1,
			input reg_addr_t rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] enc_j(input reg_addr_t rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	// expected record, from the register state left by all older instructions
	function automatic retire_rec_t expect_rec(input mem_in_t m);
		retire_rec_t     r;
		logic [31:0]     w;
		logic [6:0]      opc;
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [2:0]      f3;
		logic [xlen-1:0] imm_i;
		logic [xlen-1:0] imm_j;
		w = m.inst;
		opc = w[6:0];
		rd = w[11:7];
		f3 = w[14:12];
		rs1 = w[19:15];
		imm_i = {{52{w[31]}}, w[31:20]};
		imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		r = '0;
		r.pc = m.pc;
		r.inst = m.inst;
		r.cls = cls_plain;
		if (opc == op_load && f3 != 3'd7) begin
			r.cls = cls_load;
			r.mem_addr = m.mem_addr;
			r.mem_size = f3[1:0];
		end else if (opc == op_store && f3 <= 3'd3) begin
			r.cls = cls_store;
			r.mem_addr = m.mem_addr;
			r.mem_size = f3[1:0];
		end else if (opc == op_jal) begin
			r.target = m.pc + imm_j;
			r.cls = (rd == 5'd1) ? cls_call : cls_jump;
		end else if (opc == op_jalr) begin
			r.target = model_regs[rs1] + imm_i;
			r.target[0] = 1'b0;
			if (rd == 5'd0 && rs1 == 5'd1 && w[31:20] == 12'd0) r.cls = cls_ret;
			else if (rd == 5'd1) r.cls = cls_call;
			else r.cls = cls_jump;
		end
		return r;
	endfunction

	function automatic logic [31:0] random_inst();
		logic [31:0] w;
		w = $urandom();
		case ($urandom_range(0, 5))
			1: w[6:0] = op_load;
			2: w[6:0] = op_store;
			3: begin
				w[6:0] = op_jal;
				if ($urandom_range(0, 1) == 1) w[11:7] = reg_ra;
			end
			4: begin
				w[6:0] = op_jalr;
				case ($urandom_range(0, 3))
					0: w[31:7] = {12'd0, reg_ra, w[14:12], reg_zero};
					1: w[11:7] = reg_ra;
					2: w[11:7] = w[19:15];
					default: ;
				endcase
			end
			// anything else stays a raw random word
			default: ;
		endcase
		return w;
	endfunction

	// hold the offer until an unstalled edge takes it
	task automatic send(input logic [31:0] w, input logic wen, input logic [xlen-1:0] wdata);
		mem_in_t m;
		bit      done;
		m.pc = pc;
		m.inst = w;
		m.wen = wen;
		m.rd = w[11:7];
		m.wdata = wdata;
		m.mem_addr = {$urandom(), $urandom()};
		// jumps link pc+4, stores never write
		if (w[6:0] == op_jal || w[6:0] == op_jalr) begin
			m.wen = 1'b1;
			m.wdata = pc + 64'd4;
		end else if (w[6:0] == op_store) begin
			m.wen = 1'b0;
		end
		done = 1'b0;
		while (!done) begin
			stall = ($urandom_range(0, 99) < stall_rate);
			mem_in_valid = 1'b1;
			mem_in = m;
			if (!stall) begin
				exp_q.push_back(expect_rec(m));
				if (m.wen && m.rd != 5'd0) model_regs[m.rd] = m.wdata;
				offered++;
				done = 1'b1;
			end
			@(posedge clk);
			#2;
		end
		mem_in_valid = 1'b0;
		pc = pc + 64'd4;
	endtask

	task automatic idle();
		mem_in_valid = 1'b0;
		stall = ($urandom_range(0, 99) < stall_rate);
		@(posedge clk);
		#2;
	endtask

	// with no stall the last entry retires within two edges
	task automatic drain();
		int waited;
		mem_in_valid = 1'b0;
		stall = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < 8) begin
			@(posedge clk);
			#2;
			waited++;
		end
	endtask

	task automatic check_regs();
		for (int i = 0; i < gpr_count; i++) begin
			dbg_addr = reg_addr_t'(i);
			#1;
			assert (dbg_data == model_regs[i]) else begin
				mismatches++;
				$display("mismatch at %0t: x%0d reads %h, expected %h",
					$time, i, dbg_data, model_regs[i]);
			end
		end
	endtask

	// take the next expected record once the DUT shows one
	always @(negedge clk) begin
		if (!rst && retire_valid) begin
			if (exp_q.size() == 0) begin
				failures++;
				$display("retire record at %0t with no instruction pending", $time);
			end else begin
				exp_head = exp_q.pop_front();
				seen++;
				exp_stats.retired = exp_stats.retired + 32'd1;
				case (exp_head.cls)
					cls_load: exp_stats.loads = exp_stats.loads + 32'd1;
					cls_store: exp_stats.stores = exp_stats.stores + 32'd1;
					cls_call: exp_stats.calls = exp_stats.calls + 32'd1;
					cls_ret: exp_stats.returns = exp_stats.returns + 32'd1;
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge clk) mem_in_ready == !stall) else begin
		mismatches++;
		$display("mismatch at %0t: mem_in_ready does not follow stall", $time);
	end

	// a record may only follow an unstalled edge
	assert property (@(posedge clk) disable iff (rst) retire_valid |-> !$past(stall)) else begin
		mismatches++;
		$display("mismatch at %0t: retire record after a stalled edge", $time);
	end

	assert property (@(posedge clk) disable iff (rst) retire_valid |-> retire_rec == exp_head)
		else begin
		mismatches++;
		$display("mismatch at %0t: pc %h cls %0d target %h, expected %h %0d %h",
			$time, $sampled(retire_rec.pc), $sampled(retire_rec.cls),
			$sampled(retire_rec.target), exp_head.pc, exp_head.cls, exp_head.target);
	end

	assert property (@(posedge clk) disable iff (rst) stats == exp_stats) else begin
		mismatches++;
		$display("mismatch at %0t: retire counters differ from the model", $time);
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		void'($urandom(32'h644cc0cd));
		rst = 1'b1;
		mem_in_valid = 1'b0;
		mem_in = '0;
		stall = 1'b0;
		dbg_addr = '0;
		exp_head = '0;
		exp_stats = '0;
		pc = 64'h8000_0000;
		stall_rate = 25;
		offered = 0;
		seen = 0;
		mismatches = 0;
		failures = 0;
		for (int i = 0; i < gpr_count; i++) model_regs[i] = '0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		assert (retire_valid == 1'b0 && stats == '0) else begin
			mismatches++;
			$display("mismatch at %0t: retire state not cleared by reset", $time);
		end
		check_regs();

		// fill the register file, then try to write x0
		for (int i = 0; i < n_writes; i++) begin
			send(enc_i(7'b0010011, reg_addr_t'($urandom_range(0, 31)), 3'd0,
				reg_zero, 12'd0), 1'b1, {$urandom(), $urandom()});
		end
		send(enc_i(7'b0010011, reg_zero, 3'd0, reg_zero, 12'd0), 1'b1, '1);
		drain();
		check_regs();

		// every funct3 for loads and stores
		for (int f = 0; f < 8; f++) begin
			send(enc_i(op_load, reg_addr_t'($urandom_range(1, 31)), 3'(f),
				reg_addr_t'($urandom_range(0, 31)), 12'($urandom())),
				1'b1, {$urandom(), $urandom()});
			send(enc_s(3'(f), reg_addr_t'($urandom_range(0, 31)),
				reg_addr_t'($urandom_range(0, 31)), 12'($urandom())), 1'b0, '0);
		end

		send(enc_j(reg_ra, 21'h000100), 1'b1, '0);
		send(enc_j(reg_zero, 21'h1ffff0), 1'b1, '0);
		send(enc_j(5'd5, 21'h000804), 1'b1, '0);
		send(enc_i(op_jalr, reg_zero, 3'd0, reg_ra, 12'h000), 1'b1, '0);
		send(enc_i(op_jalr, reg_zero, 3'd0, reg_ra, 12'h004), 1'b1, '0);
		send(enc_i(op_jalr, reg_ra, 3'd0, 5'd5, 12'h008), 1'b1, '0);
		// rd equal to rs1, odd sum
		send(enc_i(op_jalr, 5'd7, 3'd0, 5'd7, 12'hffd), 1'b1, '0);
		send(enc_i(op_jalr, reg_ra, 3'd0, reg_ra, 12'h010), 1'b1, '0);
		send(enc_i(op_jalr, 5'd3, 3'd0, reg_zero, 12'h7ff), 1'b1, '0);

		for (int i = 0; i < n_random; i++) begin
			if ($urandom_range(0, 7) == 0) idle();
			send(random_inst(), 1'($urandom_range(0, 1)), {$urandom(), $urandom()});
		end

		drain();
		check_regs();
		@(posedge clk);
		#2;
		if (exp_q.size() != 0 || seen != offered) begin
			failures++;
			$display("record count wrong: %0d accepted, %0d retired", offered, seen);
		end
		assert (stats == exp_stats) else begin
			mismatches++;
			$display("mismatch at %0t: final counters differ from the model", $time);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* wb_top.sv */
module wb_top import wb_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            mem_in_valid,
	input  mem_in_t         mem_in,
	input  logic            stall,
	input  reg_addr_t       dbg_addr,
	output logic            mem_in_ready,
	output logic            retire_valid,
	output retire_rec_t     retire_rec,
	output retire_stats_t   stats,
	output logic [xlen-1:0] dbg_data
);

	wb_entry_t       entry;
	logic            retire;
	logic            gpr_we;
	reg_addr_t       gpr_waddr;
	logic [xlen-1:0] gpr_wdata;
	reg_addr_t       gpr_raddr;
	logic [xlen-1:0] gpr_rdata;
	retire_class_t   cls;

	wb_stage u_wb_stage (
		.clk          (clk),
		.rst          (rst),
		.mem_in_valid (mem_in_valid),
		.mem_in       (mem_in),
		.stall        (stall),
		.mem_in_ready (mem_in_ready),
		.entry        (entry),
		.retire       (retire),
		.gpr_we       (gpr_we),
		.gpr_waddr    (gpr_waddr),
		.gpr_wdata    (gpr_wdata)
	);

	// port a feeds jalr, port b is the debug read
	gpr_file u_gpr_file (
		.clk     (clk),
		.rst     (rst),
		.we      (gpr_we),
		.waddr   (gpr_waddr),
		.wdata   (gpr_wdata),
		.raddr_a (gpr_raddr),
		.raddr_b (dbg_addr),
		.rdata_a (gpr_rdata),
		.rdata_b (dbg_data)
	);

	retire_decode u_retire_decode (
		.clk          (clk),
		.rst          (rst),
		.retire       (retire),
		.entry        (entry),
		.gpr_rdata    (gpr_rdata),
		.gpr_raddr    (gpr_raddr),
		.cls          (cls),
		.retire_valid (retire_valid),
		.retire_rec   (retire_rec)
	);

	retire_stats u_retire_stats (
		.clk    (clk),
		.rst    (rst),
		.retire (retire),
		.cls    (cls),
		.stats  (stats)
	);

endmodule

/* retire_stats.sv */
module retire_stats import wb_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          retire,
	input  retire_class_t cls,
	output retire_stats_t stats
);

	retire_stats_t cnt_q;

	// all counters wrap naturally at 32 bits
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (retire) begin
			cnt_q.retired <= cnt_q.retired + 32'd1;
			case (cls)
				cls_load: begin
					cnt_q.loads <= cnt_q.loads + 32'd1;
				end
				cls_store: begin
					cnt_q.stores <= cnt_q.stores + 32'd1;
				end
				cls_call: begin
					cnt_q.calls <= cnt_q.calls + 32'd1;
				end
				cls_ret: begin
					cnt_q.returns <= cnt_q.returns + 32'd1;
				end
				default: begin
					// plain and other jumps only bump the total
				end
			endcase
		end
	end

	assign stats = cnt_q;

endmodule

/* retire_decode.sv */
module retire_decode import wb_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            retire,
	input  wb_entry_t       entry,
	input  logic [xlen-1:0] gpr_rdata,
	output reg_addr_t       gpr_raddr,
	output retire_class_t   cls,
	output logic            retire_valid,
	output retire_rec_t     retire_rec
);

	rv_inst_t        inst;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] jalr_sum;
	logic [xlen-1:0] target;
	logic [1:0]      mem_size;
	logic            is_mem;

	assign inst = entry.inst;

	// jalr base register comes straight from the file
	assign gpr_raddr = inst.i_fmt.rs1;

	assign imm_i = {{(xlen-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};

	// J immediate scattered over the I-type fields
	assign imm_j = {{(xlen-21){inst.i_fmt.imm12[11]}},
		inst.i_fmt.imm12[11],
		inst.i_fmt.rs1,
		inst.i_fmt.funct3,
		inst.i_fmt.imm12[0],
		inst.i_fmt.imm12[10:1],
		1'b0};

	assign jalr_sum = gpr_rdata + imm_i;

	always_comb begin
		cls      = cls_plain;
		target   = '0;
		mem_size = 2'd0;
		is_mem   = 1'b0;
		case (inst.i_fmt.opcode)
			op_load: begin
				// funct3 7 is not a defined load
				if (inst.i_fmt.funct3 != 3'd7) begin
					cls      = cls_load;
					mem_size = inst.i_fmt.funct3[1:0];
					is_mem   = 1'b1;
				end
			end
			op_store: begin
				if (!inst.s_fmt.funct3[2]) begin
					cls      = cls_store;
					mem_size = inst.s_fmt.funct3[1:0];
					is_mem   = 1'b1;
				end
			end
			op_jal: begin
				target = entry.pc + imm_j;
				cls    = (inst.i_fmt.rd == reg_ra) ? cls_call : cls_jump;
			end
			op_jalr: begin
				target = {jalr_sum[xlen-1:1], 1'b0};
				// canonical return is jalr x0, 0(ra)
				if (inst.i_fmt.rd == reg_zero && inst.i_fmt.rs1 == reg_ra &&
						inst.i_fmt.imm12 == 12'd0) begin
					cls = cls_ret;
				end else if (inst.i_fmt.rd == reg_ra) begin
					cls = cls_call;
				end else begin
					cls = cls_jump;
				end
			end
			default: begin
				cls = cls_plain;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= retire;
		end
	end

	// record only updates on a retirement, stays put otherwise
	always_ff @(posedge clk) begin
		if (retire) begin
			retire_rec.pc       <= entry.pc;
			retire_rec.inst     <= inst;
			retire_rec.cls      <= cls;
			retire_rec.target   <= target;
			retire_rec.mem_addr <= is_mem ? entry.mem_addr : '0;
			retire_rec.mem_size <= mem_size;
		end
	end

endmodule

/* wb_stage.sv */
module wb_stage import wb_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            mem_in_valid,
	input  mem_in_t         mem_in,
	input  logic            stall,
	output logic            mem_in_ready,
	output wb_entry_t       entry,
	output logic            retire,
	output logic            gpr_we,
	output reg_addr_t       gpr_waddr,
	output logic [xlen-1:0] gpr_wdata
);

	logic    valid_q;
	mem_in_t payload_q;

	// the stage accepts whenever downstream is not stalled
	assign mem_in_ready = !stall;

	// valid bit: takes the offer on every free cycle, held under stall
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (!stall) begin
			valid_q <= mem_in_valid;
		end
	end

	// payload only moves on a real transfer
	always_ff @(posedge clk) begin
		if (!stall && mem_in_valid) begin
			payload_q <= mem_in;
		end
	end

	assign entry = '{
		valid:    valid_q,
		pc:       payload_q.pc,
		inst:     payload_q.inst,
		wen:      payload_q.wen,
		rd:       payload_q.rd,
		wdata:    payload_q.wdata,
		mem_addr: payload_q.mem_addr
	};

	// an instruction leaves the stage on the first unstalled cycle
	assign retire = valid_q && !stall;

	// register write goes out together with the retirement
	assign gpr_we    = retire && payload_q.wen;
	assign gpr_waddr = payload_q.rd;
	assign gpr_wdata = payload_q.wdata;

endmodule

/* gpr_file.sv */
module gpr_file import wb_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            we,
	input  reg_addr_t       waddr,
	input  logic [xlen-1:0] wdata,
	input  reg_addr_t       raddr_a,
	input  reg_addr_t       raddr_b,
	output logic [xlen-1:0] rdata_a,
	output logic [xlen-1:0] rdata_b
);

	// x0 has no storage, entries 1..31 only
	logic [xlen-1:0] regs [1:gpr_count-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < gpr_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != reg_zero) begin
			regs[waddr] <= wdata;
		end
	end

	// reads see the contents before this edge's write
	always_comb begin
		if (raddr_a == reg_zero) begin
			rdata_a = '0;
		end else begin
			rdata_a = regs[raddr_a];
		end
	end

	// debug port
	always_comb begin
		if (raddr_b == reg_zero) begin
			rdata_b = '0;
		end else begin
			rdata_b = regs[raddr_b];
		end
	end

endmodule

/* wb_pkg.sv */
package wb_pkg;

	// machine width and register file geometry
	localparam int xlen      = 64;
	localparam int gpr_count = 32;

	typedef logic [$clog2(gpr_count)-1:0] reg_addr_t;

	// register indices with a fixed role in the calling convention
	localparam reg_addr_t reg_zero = 5'd0;
	localparam reg_addr_t reg_ra   = 5'd1;

	// major opcodes the retire decoder cares about
	localparam logic [6:0] op_load  = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_jal   = 7'b1101111;
	localparam logic [6:0] op_jalr  = 7'b1100111;

	// I-type layout, also used to rebuild the J immediate
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// S-type layout for stores
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef union packed {
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
	} rv_inst_t;

	typedef enum logic [2:0] {
		cls_plain,
		cls_load,
		cls_store,
		cls_call,
		cls_ret,
		cls_jump
	} retire_class_t;

	// what the memory stage hands over
	typedef struct packed {
		logic [xlen-1:0] pc;
		rv_inst_t        inst;
		logic            wen;
		reg_addr_t       rd;
		logic [xlen-1:0] wdata;
		logic [xlen-1:0] mem_addr;
	} mem_in_t;

	// writeback pipeline register contents
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		rv_inst_t        inst;
		logic            wen;
		reg_addr_t       rd;
		logic [xlen-1:0] wdata;
		logic [xlen-1:0] mem_addr;
	} wb_entry_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		rv_inst_t        inst;
		retire_class_t   cls;
		logic [xlen-1:0] target;
		logic [xlen-1:0] mem_addr;
		logic [1:0]      mem_size;
	} retire_rec_t;

	typedef struct packed {
		logic [31:0] retired;
		logic [31:0] loads;
		logic [31:0] stores;
		logic [31:0] calls;
		logic [31:0] returns;
	} retire_stats_t;

endpackage
